/* filelist.f */
rtl/motion_pkg.sv
rtl/motion_timing_if.sv
rtl/motion_config.sv
rtl/motion_sequencer.sv
rtl/motor_drive.sv
rtl/motion_top.sv
test/motion_checker.sv
test/motion_tb.sv

/* rtl/motion_config.sv */
`timescale 1ns/10ps
`default_nettype none

module motion_config #(
   parameter logic [motion_pkg::tick_width-1:0] default_turn_ticks  = 32'd1_250_000,
   parameter logic [motion_pkg::tick_width-1:0] default_step_ticks  = 32'd2_500_000,
   parameter logic [motion_pkg::tick_width-1:0] default_pause_ticks = 32'd25_000_000,
   parameter logic [motion_pkg::tick_width-1:0] default_calib_ticks = 32'd2_500_000
) (
   input  wire logic                                clock,
   input  wire logic                                reset,
   input  wire logic                                cfg_write,
   input  wire motion_pkg::cfg_addr_t               cfg_addr,
   input  wire logic [motion_pkg::tick_width-1:0]   cfg_data,
   motion_timing_if.regs                            timing
);

   localparam int mode_bit = motion_pkg::calib_mode_bit;

   // setting registers
   logic [motion_pkg::tick_width-1:0] turn_q;
   logic [motion_pkg::tick_width-1:0] step_q;
   logic [motion_pkg::tick_width-1:0] pause_q;
   // tick count below the mode flag
   logic [motion_pkg::tick_width-1:0] calib_q;

   ////////////////////
   // register writes
   ////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         turn_q  <= default_turn_ticks;
         step_q  <= default_step_ticks;
         pause_q <= default_pause_ticks;
         // come up in normal mode
         calib_q <= {1'b0, default_calib_ticks[mode_bit-1:0]};
      end else if (cfg_write) begin
         case (cfg_addr)
            motion_pkg::reg_turn_ticks: begin
               turn_q <= cfg_data;
            end
            motion_pkg::reg_step_ticks: begin
               step_q <= cfg_data;
            end
            motion_pkg::reg_pause_ticks: begin
               pause_q <= cfg_data;
            end
            motion_pkg::reg_calib: begin
               // mode bit and tick count written together
               calib_q <= cfg_data;
            end
         endcase
      end
   end

   ////////////////////
   // settings out
   ////////////////////

   assign timing.turn_ticks  = turn_q;
   assign timing.step_ticks  = step_q;
   assign timing.pause_ticks = pause_q;

   // strip the mode flag off the tick count
   assign timing.calib_ticks = {1'b0, calib_q[mode_bit-1:0]};
   assign timing.calib_mode  = calib_q[mode_bit];

endmodule

`default_nettype wire

/* rtl/motion_pkg.sv */
`default_nettype none

package motion_pkg;

   ////////////////////
   // field widths
   ////////////////////

   // every timing setting and every tick counter
   localparam int tick_width = 32;

   // one move command word
   localparam int command_width = 12;

   // turn count, 15 degrees per step
   localparam int angle_width = 5;

   // travel count, four inches per step
   localparam int distance_width = 7;

   // calibration-mode flag lives in the top bit of the calib register
   localparam int calib_mode_bit = tick_width - 1;

   ////////////////////
   // command word
   ////////////////////

   // normal mode: angle in the upper bits, distance below
   typedef struct packed {
      logic [angle_width-1:0]    angle;
      logic [distance_width-1:0] distance;
   } steer_fields_t;

   // calibration mode: whole word is a run length
   typedef struct packed {
      logic [command_width-1:0] duration;
   } calib_fields_t;

   // same 12 bits, read according to the mode at acceptance
   typedef union packed {
      steer_fields_t steer;
      calib_fields_t calib;
   } move_command_t;

   ////////////////////
   // drive and registers
   ////////////////////

   // direction code from sequencer to motor drive
   typedef enum logic [1:0] {
      dir_stop       = 2'b00,
      dir_forward    = 2'b01,
      dir_spin_right = 2'b10
   } drive_dir_t;

   // timing register map
   typedef enum logic [1:0] {
      reg_turn_ticks  = 2'd0,
      reg_step_ticks  = 2'd1,
      reg_pause_ticks = 2'd2,
      reg_calib       = 2'd3
   } cfg_addr_t;

endpackage

`default_nettype wire

/* rtl/motion_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module motion_sequencer (
   input  wire logic                        clock,
   input  wire logic                        reset,
   input  wire logic                        command_ready,
   input  wire motion_pkg::move_command_t   command,
   motion_timing_if.seq                     timing,
   output motion_pkg::drive_dir_t           dir,
   output logic                             move_busy,
   output logic                             move_done
);

   // padding to bring the command fields up to step counter width
   localparam int angle_pad    = motion_pkg::command_width - motion_pkg::angle_width;
   localparam int distance_pad = motion_pkg::command_width - motion_pkg::distance_width;

   // fsm states
   localparam logic [2:0] st_idle      = 3'd0;
   localparam logic [2:0] st_spin      = 3'd1;
   localparam logic [2:0] st_pause     = 3'd2;
   localparam logic [2:0] st_forward   = 3'd3;
   localparam logic [2:0] st_calibrate = 3'd4;

   logic [2:0] state_q;

   // command and mode held for the whole move
   motion_pkg::move_command_t cmd_q;
   logic                      calib_q;

   // steps done in this phase, ticks done in this step
   logic [motion_pkg::command_width-1:0] step_q;
   logic [motion_pkg::tick_width-1:0]    sub_q;

   // length of the current phase
   logic [motion_pkg::command_width-1:0] step_total;
   logic [motion_pkg::tick_width-1:0]    tick_total;

   logic has_angle;
   logic has_distance;
   logic pause_wanted;
   logic sub_last;
   logic phase_last;

   assign has_angle    = (cmd_q.steer.angle != '0);
   assign has_distance = (cmd_q.steer.distance != '0);

   // a timed pause only between a spin and a drive
   assign pause_wanted = !calib_q && has_angle && has_distance;

   ////////////////////
   // phase length
   ////////////////////

   always_comb begin
      step_total = {{(motion_pkg::command_width-1){1'b0}}, 1'b1};
      tick_total = {{(motion_pkg::tick_width-1){1'b0}}, 1'b1};
      case (state_q)
         st_spin: begin
            step_total = {{angle_pad{1'b0}}, cmd_q.steer.angle};
            tick_total = timing.turn_ticks;
         end
         st_pause: begin
            // otherwise a single motors-off cycle for an empty move
            if (pause_wanted) begin
               tick_total = timing.pause_ticks;
            end
         end
         st_forward: begin
            step_total = {{distance_pad{1'b0}}, cmd_q.steer.distance};
            tick_total = timing.step_ticks;
         end
         st_calibrate: begin
            step_total = cmd_q.calib.duration;
            tick_total = timing.calib_ticks;
         end
         default: begin
            step_total = {{(motion_pkg::command_width-1){1'b0}}, 1'b1};
         end
      endcase
   end

   assign sub_last   = (sub_q == tick_total - 1'b1);
   assign phase_last = sub_last && (step_q == step_total - 1'b1);

   ////////////////////
   // control fsm
   ////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         state_q   <= st_idle;
         calib_q   <= 1'b0;
         step_q    <= '0;
         sub_q     <= '0;
         move_done <= 1'b0;
      end else begin
         move_done <= 1'b0;
         if (state_q == st_idle) begin
            step_q <= '0;
            sub_q  <= '0;
            if (command_ready) begin
               calib_q <= timing.calib_mode;
               // first phase with a nonzero count
               if (timing.calib_mode) begin
                  state_q <= (command.calib.duration != '0) ? st_calibrate : st_pause;
               end else if (command.steer.angle != '0) begin
                  state_q <= st_spin;
               end else if (command.steer.distance != '0) begin
                  state_q <= st_forward;
               end else begin
                  state_q <= st_pause;
               end
            end
         end else if (phase_last) begin
            step_q <= '0;
            sub_q  <= '0;
            case (state_q)
               st_spin: begin
                  if (!has_distance) begin
                     state_q   <= st_idle;
                     move_done <= 1'b1;
                  end else if (timing.pause_ticks != '0) begin
                     state_q <= st_pause;
                  end else begin
                     state_q <= st_forward;
                  end
               end
               st_pause: begin
                  if (pause_wanted) begin
                     state_q <= st_forward;
                  end else begin
                     state_q   <= st_idle;
                     move_done <= 1'b1;
                  end
               end
               // forward and calibrate both end the move
               default: begin
                  state_q   <= st_idle;
                  move_done <= 1'b1;
               end
            endcase
         end else if (sub_last) begin
            // next step of the same phase
            sub_q  <= '0;
            step_q <= step_q + 1'b1;
         end else begin
            sub_q <= sub_q + 1'b1;
         end
      end
   end

   // command word latched on acceptance
   always_ff @(posedge clock) begin
      if (state_q == st_idle && command_ready) begin
         cmd_q <= command;
      end
   end

   ////////////////////
   // outputs
   ////////////////////

   // direction straight from the state
   always_comb begin
      case (state_q)
         st_spin:      dir = motion_pkg::dir_spin_right;
         st_forward:   dir = motion_pkg::dir_forward;
         st_calibrate: dir = motion_pkg::dir_forward;
         default:      dir = motion_pkg::dir_stop;
      endcase
   end

   // falls together with the done pulse
   assign move_busy = (state_q != st_idle);

endmodule

`default_nettype wire

/* rtl/motion_timing_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface motion_timing_if;

   // cycles per 15 degree turn step
   logic [motion_pkg::tick_width-1:0] turn_ticks;

   // cycles per four inch travel step
   logic [motion_pkg::tick_width-1:0] step_ticks;

   // motors-off gap between spin and drive
   logic [motion_pkg::tick_width-1:0] pause_ticks;

   // cycles per calibration interval
   logic [motion_pkg::tick_width-1:0] calib_ticks;

   // duration reading of the command word
   logic calib_mode;

   // register block side
   modport regs (output turn_ticks, step_ticks, pause_ticks, calib_ticks, calib_mode);

   // sequencer side
   modport seq (input turn_ticks, step_ticks, pause_ticks, calib_ticks, calib_mode);

endinterface

`default_nettype wire

/* rtl/motion_top.sv */
`timescale 1ns/10ps
`default_nettype none

module motion_top #(
   // reset values of the timing registers, 25 MHz clock assumed
   parameter logic [motion_pkg::tick_width-1:0] default_turn_ticks  = 32'd1_250_000,
   parameter logic [motion_pkg::tick_width-1:0] default_step_ticks  = 32'd2_500_000,
   parameter logic [motion_pkg::tick_width-1:0] default_pause_ticks = 32'd25_000_000,
   parameter logic [motion_pkg::tick_width-1:0] default_calib_ticks = 32'd2_500_000,
   // blanking on a direct drive reversal
   parameter int                                dead_ticks          = 3
) (
   input  wire logic                                 clock,
   input  wire logic                                 reset,
   input  wire logic                                 command_ready,
   input  wire logic [motion_pkg::command_width-1:0] command,
   input  wire logic                                 cfg_write,
   input  wire motion_pkg::cfg_addr_t                cfg_addr,
   input  wire logic [motion_pkg::tick_width-1:0]    cfg_data,
   output logic                                      motor_l_f,
   output logic                                      motor_r_f,
   output logic                                      motor_l_b,
   output logic                                      motor_r_b,
   output logic                                      move_busy,
   output logic                                      move_done
);

   // timing settings, register block to sequencer
   motion_timing_if timing ();

   // sequencer to motor drive
   motion_pkg::drive_dir_t dir;

   motion_config #(
      .default_turn_ticks  (default_turn_ticks),
      .default_step_ticks  (default_step_ticks),
      .default_pause_ticks (default_pause_ticks),
      .default_calib_ticks (default_calib_ticks)
   ) u_config (
      .clock     (clock),
      .reset     (reset),
      .cfg_write (cfg_write),
      .cfg_addr  (cfg_addr),
      .cfg_data  (cfg_data),
      .timing    (timing.regs)
   );

   motion_sequencer u_sequencer (
      .clock         (clock),
      .reset         (reset),
      .command_ready (command_ready),
      .command       (command),
      .timing        (timing.seq),
      .dir           (dir),
      .move_busy     (move_busy),
      .move_done     (move_done)
   );

   motor_drive #(
      .dead_ticks (dead_ticks)
   ) u_motor_drive (
      .clock     (clock),
      .reset     (reset),
      .dir       (dir),
      .motor_l_f (motor_l_f),
      .motor_r_f (motor_r_f),
      .motor_l_b (motor_l_b),
      .motor_r_b (motor_r_b)
   );

endmodule

`default_nettype wire

/* rtl/motor_drive.sv */
`timescale 1ns/10ps
`default_nettype none

module motor_drive #(
   parameter int dead_ticks = 3
) (
   input  wire logic                     clock,
   input  wire logic                     reset,
   input  wire motion_pkg::drive_dir_t   dir,
   output logic                          motor_l_f,
   output logic                          motor_r_f,
   output logic                          motor_l_b,
   output logic                          motor_r_b
);

   // room for the dead-time count, at least one bit
   localparam int dead_width = $clog2(dead_ticks + 2);

   // code the enables were last built from
   motion_pkg::drive_dir_t last_dir_q;
   // blanking cycles still to go
   logic [dead_width-1:0]  dead_q;

   logic       dir_active;
   logic       last_active;
   logic       reversal;
   // {l_f, r_f, l_b, r_b}
   logic [3:0] pattern;

   assign dir_active  = (dir == motion_pkg::dir_forward) ||
                        (dir == motion_pkg::dir_spin_right);
   assign last_active = (last_dir_q == motion_pkg::dir_forward) ||
                        (last_dir_q == motion_pkg::dir_spin_right);

   // active to a different active code, no stop in between
   assign reversal = (dead_ticks != 0) && dir_active && last_active && (dir != last_dir_q);

   ////////////////////
   // h-bridge patterns
   ////////////////////

   always_comb begin
      case (dir)
         // both front sides
         motion_pkg::dir_forward:    pattern = 4'b1100;
         // left front with right back
         motion_pkg::dir_spin_right: pattern = 4'b1001;
         default:                    pattern = 4'b0000;
      endcase
   end

   ////////////////////
   // enables with dead time
   ////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         last_dir_q <= motion_pkg::dir_stop;
         dead_q     <= '0;
         {motor_l_f, motor_r_f, motor_l_b, motor_r_b} <= 4'b0000;
      end else begin
         last_dir_q <= dir;
         if (reversal) begin
            // first blank cycle happens right here
            dead_q <= dead_width'(dead_ticks - 1);
            {motor_l_f, motor_r_f, motor_l_b, motor_r_b} <= 4'b0000;
         end else if (dead_q != '0) begin
            dead_q <= dead_q - 1'b1;
            {motor_l_f, motor_r_f, motor_l_b, motor_r_b} <= 4'b0000;
         end else begin
            {motor_l_f, motor_r_f, motor_l_b, motor_r_b} <= pattern;
         end
      end
   end

endmodule

`default_nettype wire

/* test/motion_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module motion_checker #(
   parameter int name_chars = 16
) (
   input  wire logic                    clock,
   input  wire logic                    reset,
   input  wire logic                    motor_l_f,
   input  wire logic                    motor_r_f,
   input  wire logic                    motor_l_b,
   input  wire logic                    motor_r_b,
   input  wire logic                    move_busy,
   input  wire logic                    move_done,
   input  wire logic [8*name_chars-1:0] test_name,
   input  int                           test_index,
   input  int                           exp_spin,
   input  int                           exp_gap,
   input  int                           exp_forward,
   output int                           error_count
);

   // busy one cycle back since the enables trail the direction code by a cycle
   logic                    busy_d;
   logic                    spin_seen;
   logic                    forward_seen;
   // {l_f, r_f, l_b, r_b}
   logic [3:0]              pattern;
   logic [8*name_chars-1:0] label;
   int                      spin_count;
   int                      gap_count;
   int                      forward_count;
   // test that gave the latest done pulse
   int                      last_done_index;

   initial begin
      error_count     = 0;
      last_done_index = -1;
   end

   task automatic check_count(input string what, input int expected, input int actual);
      if (expected != actual) begin
         error_count++;
         $display("[ERROR] %0s %0s: expected %0d, actual %0d", label, what, expected, actual);
      end
   endtask

   task automatic clear_counts();
      spin_count    = 0;
      gap_count     = 0;
      forward_count = 0;
      spin_seen     = 1'b0;
      forward_seen  = 1'b0;
   endtask

   ////////////////////
   // pattern counting
   ////////////////////

   always @(posedge clock) begin
      pattern = {motor_l_f, motor_r_f, motor_l_b, motor_r_b};
      label   = (test_index < 0) ? "reset" : test_name;
      if (reset) begin
         busy_d = 1'b0;
         clear_counts();
      end else begin
         // nothing runs before the first command
         if (test_index < 0) begin
            check_count("idle busy", 0, int'(move_busy));
         end
         // quiet between moves
         if (!move_busy && !busy_d) begin
            check_count("idle enables", 0, int'(pattern));
            if (move_done) begin
               error_count++;
               $display("%0s: move_done pulsed with no move running", label);
            end
         end
         if (busy_d) begin
            case (pattern)
               4'b1001: begin
                  spin_count++;
                  spin_seen = 1'b1;
               end
               4'b1100: begin
                  forward_count++;
                  forward_seen = 1'b1;
               end
               4'b0000: begin
                  // only the gap between spin and drive counts as pause
                  if (spin_seen && !forward_seen) begin
                     gap_count++;
                  end
               end
               default: begin
                  error_count++;
                  $display("%0s: motor enables show an illegal pattern %b", label, pattern);
               end
            endcase
         end
         if (move_done) begin
            if (move_busy || !busy_d) begin
               error_count++;
               $display("%0s: move_done did not line up with move_busy falling", label);
            end
            if (test_index == last_done_index) begin
               error_count++;
               $display("%0s: a second move_done pulse arrived in one test", label);
            end else begin
               check_count("spin cycles", exp_spin, spin_count);
               check_count("pause cycles", exp_gap, gap_count);
               check_count("forward cycles", exp_forward, forward_count);
            end
            last_done_index = test_index;
            clear_counts();
         end
         busy_d = move_busy;
      end
   end

endmodule

`default_nettype wire

/* test/motion_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module motion_tb;

   localparam int clock_period = 4;
   localparam int num_tests    = 11;
   localparam int name_chars   = 16;
   // slack per test for writes, strobes and the idle gap
   localparam int test_margin  = 40;

   // small register defaults keep moves short
   localparam logic [31:0] tb_turn_ticks  = 32'd3;
   localparam logic [31:0] tb_step_ticks  = 32'd2;
   localparam logic [31:0] tb_pause_ticks = 32'd5;
   localparam logic [31:0] tb_calib_ticks = 32'd4;
   localparam int          tb_dead_ticks  = 3;

   // angle 1, distance 1, sent while busy
   localparam logic [motion_pkg::command_width-1:0] extra_word = 12'h081;

   typedef struct packed {
      logic [8*name_chars-1:0]              name;
      logic                                 has_write;
      motion_pkg::cfg_addr_t                addr;
      logic [motion_pkg::tick_width-1:0]    data;
      logic [motion_pkg::command_width-1:0] word;
      logic                                 extra;
   } test_entry_t;

   logic                                 clock;
   logic                                 reset;
   logic                                 command_ready;
   logic [motion_pkg::command_width-1:0] command;
   logic                                 cfg_write;
   motion_pkg::cfg_addr_t                cfg_addr;
   logic [motion_pkg::tick_width-1:0]    cfg_data;
   logic                                 motor_l_f;
   logic                                 motor_r_f;
   logic                                 motor_l_b;
   logic                                 motor_r_b;
   logic                                 move_busy;
   logic                                 move_done;

   // expectations for the checker
   logic [8*name_chars-1:0] test_name;
   int                      test_index;
   int                      exp_spin;
   int                      exp_gap;
   int                      exp_forward;
   int                      checker_errors;
   int                      tb_errors;

   test_entry_t table_q [num_tests];
   logic        table_loaded = 1'b0;

   // register contents as last written
   int   turn_ticks;
   int   step_ticks;
   int   pause_ticks;
   int   calib_ticks;
   logic calib_mode;

   always #(clock_period / 2) clock = ~clock;

   motion_top #(
      .default_turn_ticks  (tb_turn_ticks),
      .default_step_ticks  (tb_step_ticks),
      .default_pause_ticks (tb_pause_ticks),
      .default_calib_ticks (tb_calib_ticks),
      .dead_ticks          (tb_dead_ticks)
   ) u_dut (
      .clock         (clock),
      .reset         (reset),
      .command_ready (command_ready),
      .command       (command),
      .cfg_write     (cfg_write),
      .cfg_addr      (cfg_addr),
      .cfg_data      (cfg_data),
      .motor_l_f     (motor_l_f),
      .motor_r_f     (motor_r_f),
      .motor_l_b     (motor_l_b),
      .motor_r_b     (motor_r_b),
      .move_busy     (move_busy),
      .move_done     (move_done)
   );

   motion_checker #(
      .name_chars (name_chars)
   ) u_checker (
      .clock       (clock),
      .reset       (reset),
      .motor_l_f   (motor_l_f),
      .motor_r_f   (motor_r_f),
      .motor_l_b   (motor_l_b),
      .motor_r_b   (motor_r_b),
      .move_busy   (move_busy),
      .move_done   (move_done),
      .test_name   (test_name),
      .test_index  (test_index),
      .exp_spin    (exp_spin),
      .exp_gap     (exp_gap),
      .exp_forward (exp_forward),
      .error_count (checker_errors)
   );

   ////////////////////
   // stimulus table
   ////////////////////

   function automatic test_entry_t make_entry(input logic [8*name_chars-1:0] name,
      input logic has_write, input motion_pkg::cfg_addr_t addr, input logic [31:0] data,
      input logic [4:0] angle, input logic [6:0] distance, input logic extra);
      test_entry_t entry;
      entry.name      = name;
      entry.has_write = has_write;
      entry.addr      = addr;
      entry.data      = data;
      entry.word      = {angle, distance};
      entry.extra     = extra;
      return entry;
   endfunction

   task automatic load_table();
      motion_pkg::cfg_addr_t no_addr;
      no_addr = motion_pkg::reg_turn_ticks;
      //                    name             wr    address                      data
      table_q[0]  = make_entry("normal_move",   0, no_addr, 0, 2, 3, 0);
      table_q[1]  = make_entry("distance_only", 0, no_addr, 0, 0, 4, 0);
      table_q[2]  = make_entry("angle_only",    0, no_addr, 0, 3, 0, 0);
      table_q[3]  = make_entry("empty_move",    0, no_addr, 0, 0, 0, 0);
      table_q[4]  = make_entry("busy_strobe",   0, no_addr, 0, 1, 2, 1);
      table_q[5]  = make_entry("turn_write",    1, motion_pkg::reg_turn_ticks, 1, 4, 1, 0);
      table_q[6]  = make_entry("step_write",    1, motion_pkg::reg_step_ticks, 4, 2, 3, 0);
      table_q[7]  = make_entry("pause_write",   1, motion_pkg::reg_pause_ticks, 2, 2, 2, 0);
      // duration 5 sits in the low bits of the word
      table_q[8]  = make_entry("calib_run",     1, motion_pkg::reg_calib, 32'h8000_0004, 0, 5, 0);
      table_q[9]  = make_entry("calib_zero",    0, no_addr, 0, 0, 0, 0);
      table_q[10] = make_entry("calib_off",     1, motion_pkg::reg_calib, 32'h0000_0004, 1, 1, 0);
   endtask

   ////////////////////
   // reference model
   ////////////////////

   task automatic track_write(input motion_pkg::cfg_addr_t addr, input logic [31:0] data,
      inout int turn, inout int step, inout int pause, inout int calib, inout logic mode);
      case (addr)
         motion_pkg::reg_turn_ticks:  turn  = data;
         motion_pkg::reg_step_ticks:  step  = data;
         motion_pkg::reg_pause_ticks: pause = data;
         default: begin
            // top bit is the mode flag
            calib = {1'b0, data[30:0]};
            mode  = data[31];
         end
      endcase
   endtask

   task automatic predict_counts(input motion_pkg::move_command_t word, input logic mode,
      input int turn, input int step, input int pause, input int calib,
      output int spin, output int gap, output int forward);
      int angle;
      int distance;
      angle    = int'(word.steer.angle);
      distance = int'(word.steer.distance);
      if (mode) begin
         spin    = 0;
         gap     = 0;
         forward = int'(word.calib.duration) * calib;
      end else begin
         spin    = angle * turn;
         gap     = (angle != 0 && distance != 0) ? pause : 0;
         forward = distance * step;
      end
   endtask

   // one clock, remembering a done pulse
   task automatic step_watch(inout logic seen);
      @(posedge clock);
      if (move_done) begin
         seen = 1'b1;
      end
   endtask

   task automatic run_test(input int i);
      test_entry_t entry;
      int          spin;
      int          gap;
      int          forward;
      int          limit;
      int          waited;
      logic        got_done;
      entry = table_q[i];
      if (entry.has_write) begin
         cfg_write <= 1'b1;
         cfg_addr  <= entry.addr;
         cfg_data  <= entry.data;
         @(posedge clock);
         cfg_write <= 1'b0;
         track_write(entry.addr, entry.data, turn_ticks, step_ticks, pause_ticks,
                     calib_ticks, calib_mode);
         @(posedge clock);
      end
      predict_counts(entry.word, calib_mode, turn_ticks, step_ticks, pause_ticks,
                     calib_ticks, spin, gap, forward);
      test_index    <= i;
      test_name     <= entry.name;
      exp_spin      <= spin;
      exp_gap       <= gap;
      exp_forward   <= forward;
      command_ready <= 1'b1;
      command       <= entry.word;
      got_done = 1'b0;
      step_watch(got_done);
      command_ready <= 1'b0;
      if (entry.extra) begin
         // second strobe lands while busy
         step_watch(got_done);
         command_ready <= 1'b1;
         command       <= extra_word;
         step_watch(got_done);
         command_ready <= 1'b0;
      end
      limit  = spin + gap + forward + 20;
      waited = 0;
      while (!got_done && waited < limit) begin
         step_watch(got_done);
         waited++;
      end
      if (!got_done) begin
         tb_errors++;
         $display("%0s: no move_done within %0d cycles", entry.name, limit);
      end
      repeat (10) @(posedge clock);
   endtask

   ////////////////////
   // main sequence
   ////////////////////

   initial begin
      clock         = 1'b0;
      reset         = 1'b1;
      command_ready = 1'b0;
      command       = '0;
      cfg_write     = 1'b0;
      cfg_addr      = motion_pkg::reg_turn_ticks;
      cfg_data      = '0;
      test_name     = '0;
      test_index    = -1;
      exp_spin      = 0;
      exp_gap       = 0;
      exp_forward   = 0;
      tb_errors     = 0;
      turn_ticks    = tb_turn_ticks;
      step_ticks    = tb_step_ticks;
      pause_ticks   = tb_pause_ticks;
      calib_ticks   = tb_calib_ticks;
      calib_mode    = 1'b0;
      load_table();
      table_loaded = 1'b1;
      repeat (8) @(posedge clock);
      reset <= 1'b0;
      // idle window, the checker watches for stray enables
      repeat (5) @(posedge clock);
      for (int i = 0; i < num_tests; i++) begin
         run_test(i);
      end
      $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
      if (checker_errors + tb_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   ////////////////////
   // watchdog
   ////////////////////

   initial begin : watchdog
      test_entry_t entry;
      int          budget;
      int          spin;
      int          gap;
      int          forward;
      int          turn;
      int          step;
      int          pause;
      int          calib;
      logic        mode;
      wait (table_loaded);
      turn   = tb_turn_ticks;
      step   = tb_step_ticks;
      pause  = tb_pause_ticks;
      calib  = tb_calib_ticks;
      mode   = 1'b0;
      // reset plus the idle window
      budget = 20;
      for (int i = 0; i < num_tests; i++) begin
         entry = table_q[i];
         if (entry.has_write) begin
            track_write(entry.addr, entry.data, turn, step, pause, calib, mode);
         end
         predict_counts(entry.word, mode, turn, step, pause, calib, spin, gap, forward);
         budget += spin + gap + forward + test_margin;
      end
      #(budget * clock_period);
      tb_errors++;
      $display("simulation timed out after %0d cycles", budget);
      $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire
